// ==== verilog/alu_pkg.sv ====
package alu_pkg;

	// ========================================================================
	// Datapath sizing
	// ========================================================================
	localparam int DBW = 64;
	localparam int ITER_COUNT = 64;		// Steps per multiply or divide

	// Result for anything the unit does not decode
	localparam logic [DBW-1:0] POISON = 64'hDEADDEADDEADDEAD;

	// ========================================================================
	// Opcodes
	// ========================================================================
	localparam logic [7:0] OP_CMP = 8'h10;
	localparam logic [7:0] OP_CMPI = 8'h20;
	localparam logic [7:0] OP_RR = 8'h40;
	localparam logic [7:0] OP_R = 8'h41;
	localparam logic [7:0] OP_LOGIC = 8'h42;
	localparam logic [7:0] OP_ADDI = 8'h48;
	localparam logic [7:0] OP_SUBI = 8'h49;
	localparam logic [7:0] OP_MULI = 8'h4C;
	localparam logic [7:0] OP_MULUI = 8'h4D;
	localparam logic [7:0] OP_DIVI = 8'h4E;
	localparam logic [7:0] OP_DIVUI = 8'h4F;
	localparam logic [7:0] OP_ANDI = 8'h53;
	localparam logic [7:0] OP_ORI = 8'h54;
	localparam logic [7:0] OP_EORI = 8'h55;
	localparam logic [7:0] OP_SHIFT = 8'h58;
	localparam logic [7:0] OP_ADD4UI = 8'h6B;
	localparam logic [7:0] OP_LOAD = 8'h86;		// Base plus displacement
	localparam logic [7:0] OP_LOADX = 8'hB6;	// Base plus scaled index
	localparam logic [7:0] OP_JSR = 8'hA2;

	// Function codes under OP_RR
	localparam logic [5:0] FN_ADD = 6'd0;
	localparam logic [5:0] FN_SUB = 6'd1;
	localparam logic [5:0] FN_ADD4U = 6'd9;
	localparam logic [5:0] FN_MIN = 6'd10;
	localparam logic [5:0] FN_MAX = 6'd11;
	localparam logic [5:0] FN_MUL = 6'd12;
	localparam logic [5:0] FN_DIV = 6'd13;
	localparam logic [5:0] FN_MULU = 6'd14;
	localparam logic [5:0] FN_DIVU = 6'd15;

	// Function codes under OP_R, only bits 3:0 are significant
	localparam logic [5:0] FN_MOV = 6'd0;
	localparam logic [5:0] FN_NEG = 6'd1;
	localparam logic [5:0] FN_COM = 6'd2;
	localparam logic [5:0] FN_ABS = 6'd3;
	localparam logic [5:0] FN_CNTLZ = 6'd4;
	localparam logic [5:0] FN_CNTLO = 6'd5;
	localparam logic [5:0] FN_CNTPOP = 6'd6;
	localparam logic [5:0] FN_SXB = 6'd8;
	localparam logic [5:0] FN_ZXB = 6'd9;
	localparam logic [5:0] FN_SXH = 6'd10;
	localparam logic [5:0] FN_ZXH = 6'd11;

	// Function codes under OP_LOGIC
	localparam logic [5:0] FN_AND = 6'd0;
	localparam logic [5:0] FN_ANDC = 6'd1;
	localparam logic [5:0] FN_OR = 6'd2;
	localparam logic [5:0] FN_ORC = 6'd3;
	localparam logic [5:0] FN_EOR = 6'd4;
	localparam logic [5:0] FN_NAND = 6'd5;
	localparam logic [5:0] FN_NOR = 6'd6;
	localparam logic [5:0] FN_ENOR = 6'd7;

	// Function codes under OP_SHIFT
	localparam logic [5:0] FN_SHL = 6'd0;
	localparam logic [5:0] FN_SHR = 6'd1;
	localparam logic [5:0] FN_ASR = 6'd3;
	localparam logic [5:0] FN_ROL = 6'd4;
	localparam logic [5:0] FN_ROR = 6'd5;

endpackage

// ==== verilog/alu_multiplier.sv ====
`timescale 1ns/1ps

module alu_multiplier (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic sgn,
	input  logic [alu_pkg::DBW-1:0] a,
	input  logic [alu_pkg::DBW-1:0] b,
	output logic [2*alu_pkg::DBW-1:0] prod,
	output logic done
);
	import alu_pkg::*;

	logic busy;
	logic neg;					// Product sign flip pending
	logic [6:0] cnt;
	logic [DBW-1:0] mag_a;
	logic [DBW-1:0] mag_b;
	logic [DBW-1:0] mcand;
	logic [2*DBW-1:0] acc;		// Upper half partial sum, lower half multiplier
	logic [DBW:0] sum;

	assign mag_a = (sgn && a[DBW-1]) ? -a : a;
	assign mag_b = (sgn && b[DBW-1]) ? -b : b;

	// Add multiplicand in when the current multiplier bit is set
	assign sum = {1'b0, acc[2*DBW-1:DBW]} + {1'b0, (acc[0] ? mcand : {DBW{1'b0}})};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			neg <= 1'b0;
			cnt <= '0;
		end
		else if (start && !busy)
		begin
			busy <= 1'b1;
			neg <= sgn && (a[DBW-1] ^ b[DBW-1]);
			cnt <= '0;
		end
		else if (busy)
		begin
			cnt <= cnt + 7'd1;
			if (cnt == 7'(ITER_COUNT - 1))
				busy <= 1'b0;		// Last step
		end
	end

	always_ff @(posedge clk)
	begin
		if (start && !busy)
		begin
			mcand <= mag_a;
			acc <= {{DBW{1'b0}}, mag_b};
		end
		else if (busy)
			acc <= {sum, acc[DBW-1:1]};	// Shift right one place
	end

	assign prod = neg ? -acc : acc;
	assign done = !busy;

	// Done drops for the full run and comes back right after it
	a_done_low: assert property (@(posedge clk) disable iff (!rst_n)
		(start && done) |=> !done [*ITER_COUNT] ##1 done)
		else $error("multiplier done timing wrong");

endmodule

// ==== verilog/alu_divider.sv ====
`timescale 1ns/1ps

module alu_divider (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic sgn,
	input  logic [alu_pkg::DBW-1:0] a,
	input  logic [alu_pkg::DBW-1:0] b,
	output logic [alu_pkg::DBW-1:0] quo,
	output logic [alu_pkg::DBW-1:0] rem,
	output logic dvz,
	output logic done
);
	import alu_pkg::*;

	logic busy;
	logic neg_q;
	logic neg_r;
	logic [6:0] cnt;
	logic [DBW-1:0] mag_a;
	logic [DBW-1:0] mag_b;
	logic [DBW-1:0] dvd;		// Dividend out at the top, quotient in at the bottom
	logic [DBW-1:0] dvs;
	logic [DBW-1:0] part;		// Partial remainder
	logic [DBW:0] trial_in;
	logic [DBW+1:0] trial;
	logic fits;

	assign mag_a = (sgn && a[DBW-1]) ? -a : a;
	assign mag_b = (sgn && b[DBW-1]) ? -b : b;

	// Trial subtract, keep the result only if no borrow
	assign trial_in = {part, dvd[DBW-1]};
	assign trial = {1'b0, trial_in} - {2'b00, dvs};
	assign fits = !trial[DBW+1];

	// ========================================================================
	// Control
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			done <= 1'b1;
			dvz <= 1'b0;
			neg_q <= 1'b0;
			neg_r <= 1'b0;
			cnt <= '0;
		end
		else if (start && !busy)
		begin
			busy <= 1'b1;
			done <= 1'b0;
			dvz <= 1'b0;
			neg_q <= sgn && (a[DBW-1] ^ b[DBW-1]);
			neg_r <= sgn && a[DBW-1];		// Remainder follows the dividend
			cnt <= '0;
		end
		else if (busy)
		begin
			cnt <= cnt + 7'd1;
			if (cnt == 7'(ITER_COUNT - 1))
			begin
				busy <= 1'b0;
				done <= 1'b1;
				dvz <= dvs == '0;
			end
		end
	end

	// ========================================================================
	// Datapath
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (start && !busy)
		begin
			dvd <= mag_a;
			dvs <= mag_b;
			part <= '0;
		end
		else if (busy)
		begin
			part <= fits ? trial[DBW-1:0] : trial_in[DBW-1:0];
			dvd <= {dvd[DBW-2:0], fits};
		end
	end

	// Truncating signed result, all ones on a zero divisor
	assign quo = dvz ? {DBW{1'b1}} : (neg_q ? -dvd : dvd);
	assign rem = neg_r ? -part : part;

	a_dvz_idle: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !dvz)
		else $error("divide by zero flag raised while busy");

	a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!(done && busy))
		else $error("divider done while busy");

endmodule

// ==== verilog/alu_shifter.sv ====
`timescale 1ns/1ps

module alu_shifter (
	input  logic [5:0] fn,
	input  logic [alu_pkg::DBW-1:0] a,
	input  logic [5:0] amt,
	output logic [alu_pkg::DBW-1:0] o
);
	import alu_pkg::*;

	logic [2*DBW-1:0] rot_l;
	logic [2*DBW-1:0] rot_r;

	// Rotates from a doubled word
	assign rot_l = {a, a} << amt;
	assign rot_r = {a, a} >> amt;

	always_comb
	begin
		case (fn)
		FN_SHL:
			o = a << amt;
		FN_SHR:
			o = a >> amt;
		FN_ASR:
			o = $signed(a) >>> amt;		// Sign fill
		FN_ROL:
			o = rot_l[2*DBW-1:DBW];
		FN_ROR:
			o = rot_r[DBW-1:0];
		default:
			o = POISON;
		endcase
	end

endmodule

// ==== verilog/alu_bitcount.sv ====
`timescale 1ns/1ps

module alu_bitcount (
	input  logic [alu_pkg::DBW-1:0] a,
	output logic [6:0] clz,
	output logic [6:0] clo,
	output logic [6:0] pop
);
	import alu_pkg::*;

	logic [3:0] byte_cnt [DBW/8];

	// Highest set bit wins, zero input gives the full width
	function automatic logic [6:0] lead_zeros(input logic [DBW-1:0] v);
		logic [6:0] n;
		n = 7'(DBW);
		for (int i = 0; i < DBW; i++)
			if (v[i])
				n = 7'(DBW - 1 - i);
		return n;
	endfunction

	assign clz = lead_zeros(a);
	assign clo = lead_zeros(~a);		// Leading ones of a

	// Per-byte counts first
	always_comb
	begin
		for (int k = 0; k < DBW/8; k++)
		begin
			byte_cnt[k] = 4'd0;
			for (int j = 0; j < 8; j++)
				byte_cnt[k] = byte_cnt[k] + 4'(a[8*k+j]);
		end
	end

	// Then the byte sums
	always_comb
	begin
		pop = 7'd0;
		for (int k = 0; k < DBW/8; k++)
			pop = pop + 7'(byte_cnt[k]);
	end

endmodule

// ==== verilog/alu_core.sv ====
`timescale 1ns/1ps

module alu_core (
	input  logic clk,
	input  logic rst_n,
	input  logic ld,
	input  logic [7:0] op,
	input  logic [5:0] fn,
	input  logic [alu_pkg::DBW-1:0] arg_a,
	input  logic [alu_pkg::DBW-1:0] arg_b,
	input  logic [alu_pkg::DBW-1:0] arg_c,
	input  logic [alu_pkg::DBW-1:0] arg_i,
	input  logic [alu_pkg::DBW-1:0] pc,
	input  logic [3:0] insn_size,
	output logic [alu_pkg::DBW-1:0] result,
	output logic done,
	output logic div_by_zero
);
	import alu_pkg::*;

	logic is_mul;
	logic is_div;
	logic is_imm;
	logic mul_sgn;
	logic div_sgn;
	logic mul_done;
	logic div_done;
	logic [DBW-1:0] op_b;
	logic [2*DBW-1:0] prod;
	logic [DBW-1:0] quo;
	logic [DBW-1:0] shift_o;
	logic [6:0] clz;
	logic [6:0] clo;
	logic [6:0] pop;
	logic [DBW-1:0] cmp_b;
	logic [3:0] flags;
	logic [DBW-1:0] index;

	// ========================================================================
	// Iterative unit decode
	// ========================================================================
	assign is_mul = (op == OP_RR && (fn == FN_MUL || fn == FN_MULU)) ||
		op == OP_MULI || op == OP_MULUI;
	assign is_div = (op == OP_RR && (fn == FN_DIV || fn == FN_DIVU)) ||
		op == OP_DIVI || op == OP_DIVUI;
	assign mul_sgn = (op == OP_RR && fn == FN_MUL) || op == OP_MULI;
	assign div_sgn = (op == OP_RR && fn == FN_DIV) || op == OP_DIVI;
	assign is_imm = op == OP_MULI || op == OP_MULUI || op == OP_DIVI || op == OP_DIVUI;
	assign op_b = is_imm ? arg_i : arg_b;

	alu_multiplier mul_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(ld && is_mul),
		.sgn(mul_sgn),
		.a(arg_a),
		.b(op_b),
		.prod(prod),
		.done(mul_done)
	);

	alu_divider div_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(ld && is_div),
		.sgn(div_sgn),
		.a(arg_a),
		.b(op_b),
		.quo(quo),
		.rem(),
		.dvz(div_by_zero),
		.done(div_done)
	);

	alu_shifter shift_i (
		.fn(fn),
		.a(arg_a),
		.amt(arg_b[5:0]),
		.o(shift_o)
	);

	alu_bitcount count_i (
		.a(arg_a),
		.clz(clz),
		.clo(clo),
		.pop(pop)
	);

	// Flag nibble is {0, unsigned lt, signed lt, eq}
	assign cmp_b = (op == OP_CMPI) ? arg_i : arg_b;
	assign flags = {1'b0, arg_a < cmp_b, $signed(arg_a) < $signed(cmp_b), arg_a == cmp_b};
	assign index = arg_b << fn[1:0];

	// ========================================================================
	// Result select
	// ========================================================================
	always_comb
	begin
		result = POISON;
		case (op)
		OP_RR:
			case (fn)
			FN_ADD:		result = arg_a + arg_b;
			FN_SUB:		result = arg_a - arg_b;
			FN_ADD4U:	result = (arg_a << 2) + arg_b;
			FN_MIN:		result = (arg_a < arg_b) ? arg_a : arg_b;	// Unsigned compare
			FN_MAX:		result = (arg_a < arg_b) ? arg_b : arg_a;
			FN_MUL, FN_MULU:	result = prod[DBW-1:0];
			FN_DIV, FN_DIVU:	result = quo;
			default:	result = POISON;
			endcase
		OP_R:
			case ({2'b00, fn[3:0]})
			FN_MOV:		result = arg_a;
			FN_NEG:		result = -arg_a;
			FN_COM:		result = ~arg_a;
			FN_ABS:		result = arg_a[DBW-1] ? -arg_a : arg_a;
			FN_CNTLZ:	result = {{(DBW-7){1'b0}}, clz};
			FN_CNTLO:	result = {{(DBW-7){1'b0}}, clo};
			FN_CNTPOP:	result = {{(DBW-7){1'b0}}, pop};
			FN_SXB:		result = {{(DBW-8){arg_a[7]}}, arg_a[7:0]};
			FN_ZXB:		result = {{(DBW-8){1'b0}}, arg_a[7:0]};
			FN_SXH:		result = {{(DBW-32){arg_a[31]}}, arg_a[31:0]};
			FN_ZXH:		result = {{(DBW-32){1'b0}}, arg_a[31:0]};
			default:	result = POISON;
			endcase
		OP_LOGIC:
			case (fn)
			FN_AND:		result = arg_a & arg_b;
			FN_ANDC:	result = arg_a & ~arg_b;
			FN_OR:		result = arg_a | arg_b;
			FN_ORC:		result = arg_a | ~arg_b;
			FN_EOR:		result = arg_a ^ arg_b;
			FN_NAND:	result = ~(arg_a & arg_b);
			FN_NOR:		result = ~(arg_a | arg_b);
			FN_ENOR:	result = ~(arg_a ^ arg_b);
			default:	result = POISON;
			endcase
		OP_CMP, OP_CMPI:	result = {16{flags}};
		OP_SHIFT:	result = shift_o;
		OP_ADDI:	result = arg_a + arg_i;
		OP_SUBI:	result = arg_a - arg_i;
		OP_ANDI:	result = arg_a & arg_i;
		OP_ORI:		result = arg_a | arg_i;
		OP_EORI:	result = arg_a ^ arg_i;
		OP_ADD4UI:	result = (arg_a << 2) + arg_i;
		OP_MULI, OP_MULUI:	result = prod[DBW-1:0];
		OP_DIVI, OP_DIVUI:	result = quo;
		OP_LOAD:	result = arg_a + arg_c + arg_i;
		OP_LOADX:	result = arg_a + arg_c + index;		// Scaled index
		OP_JSR:		result = pc + {{(DBW-4){1'b0}}, insn_size};	// Link address
		default:	result = POISON;
		endcase
	end

	// Only the iterative ops take more than a cycle
	always_comb
	begin
		done = 1'b1;
		if (is_mul)
			done = mul_done;
		else if (is_div)
			done = div_done;
	end

	a_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		!(is_mul || is_div) |-> done)
		else $error("done low on a single cycle op");

endmodule

// ==== sim/alu_checker.sv ====
`timescale 1ns/1ps

module alu_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic chk_en,
	input  logic ld,
	input  logic [7:0] op,
	input  logic [5:0] fn,
	input  logic [alu_pkg::DBW-1:0] arg_a,
	input  logic [alu_pkg::DBW-1:0] arg_b,
	input  logic [alu_pkg::DBW-1:0] arg_c,
	input  logic [alu_pkg::DBW-1:0] arg_i,
	input  logic [alu_pkg::DBW-1:0] pc,
	input  logic [3:0] insn_size,
	input  logic [alu_pkg::DBW-1:0] result,
	input  logic done,
	input  logic div_by_zero,
	output int errors
);
	import alu_pkg::*;

	int err_cnt = 0;
	logic ld_prev;		// Iterative op was loaded on the last edge
	logic div_prev;
	logic exp_dvz;
	logic div_op;
	logic iter_op;
	logic [DBW-1:0] divisor;

	assign errors = err_cnt;
	assign div_op = (op == OP_RR && (fn == FN_DIV || fn == FN_DIVU)) ||
		op == OP_DIVI || op == OP_DIVUI;
	assign iter_op = div_op || (op == OP_RR && (fn == FN_MUL || fn == FN_MULU)) ||
		op == OP_MULI || op == OP_MULUI;
	assign divisor = (op == OP_DIVI || op == OP_DIVUI) ? arg_i : arg_b;

	// Length of the run of value b starting at the top bit
	function automatic logic [DBW-1:0] lead_run(input logic [DBW-1:0] v, input logic b);
		int n;
		logic run;
		n = 0;
		run = 1'b1;
		for (int k = DBW - 1; k >= 0; k--)
		begin
			run = run && (v[k] == b);
			if (run)
				n++;
		end
		return DBW'(n);
	endfunction

	// Magnitude divide, then fix the sign, truncating toward zero
	function automatic logic [DBW-1:0] divide(input logic [DBW-1:0] n,
		input logic [DBW-1:0] d, input logic sgn);
		logic [DBW-1:0] mn;
		logic [DBW-1:0] md;
		logic [DBW-1:0] q;
		if (d == '0)
			return '1;
		mn = (sgn && n[DBW-1]) ? ~n + 1'b1 : n;
		md = (sgn && d[DBW-1]) ? ~d + 1'b1 : d;
		q = mn / md;
		return (sgn && (n[DBW-1] != d[DBW-1])) ? ~q + 1'b1 : q;
	endfunction

	// ========================================================================
	// Reference model
	// ========================================================================
	function automatic logic [DBW-1:0] model(input logic [7:0] o, input logic [5:0] f,
		input logic [DBW-1:0] a, input logic [DBW-1:0] b, input logic [DBW-1:0] c,
		input logic [DBW-1:0] i, input logic [DBW-1:0] p, input logic [3:0] sz);
		logic [DBW-1:0] bc;
		logic slt;
		bc = (o == OP_CMPI) ? i : b;
		slt = (a[DBW-1] != bc[DBW-1]) ? a[DBW-1] : (a < bc);
		case (o)
		OP_RR:
			case (f)
			FN_ADD: return a + b;
			FN_SUB: return a - b;
			FN_ADD4U: return a * 4 + b;
			FN_MIN: return (a < b) ? a : b;
			FN_MAX: return (a > b) ? a : b;
			FN_MUL, FN_MULU: return a * b;		// Low half, sign independent
			FN_DIV: return divide(a, b, 1'b1);
			FN_DIVU: return divide(a, b, 1'b0);
			default: return POISON;
			endcase
		OP_R:
			case (f[3:0])
			4'd0: return a;
			4'd1: return '0 - a;
			4'd2: return ~a;
			4'd3: return a[DBW-1] ? '0 - a : a;
			4'd4: return lead_run(a, 1'b0);
			4'd5: return lead_run(a, 1'b1);
			4'd6: return DBW'($countones(a));
			4'd8: return DBW'($signed(a[7:0]));
			4'd9: return DBW'(a[7:0]);
			4'd10: return DBW'($signed(a[31:0]));
			4'd11: return DBW'(a[31:0]);
			default: return POISON;
			endcase
		OP_LOGIC:
			case (f)
			FN_AND: return a & b;
			FN_ANDC: return a & ~b;
			FN_OR: return a | b;
			FN_ORC: return a | ~b;
			FN_EOR: return a ^ b;
			FN_NAND: return ~(a & b);
			FN_NOR: return ~(a | b);
			FN_ENOR: return ~(a ^ b);
			default: return POISON;
			endcase
		OP_CMP, OP_CMPI: return {16{1'b0, a < bc, slt, a == bc}};
		OP_SHIFT:
			case (f)
			FN_SHL: return a << b[5:0];
			FN_SHR: return a >> b[5:0];
			FN_ASR: return DBW'({{DBW{a[DBW-1]}}, a} >> b[5:0]);
			FN_ROL: return (a << b[5:0]) | (a >> (DBW - int'(b[5:0])));
			FN_ROR: return (a >> b[5:0]) | (a << (DBW - int'(b[5:0])));
			default: return POISON;
			endcase
		OP_ADDI: return a + i;
		OP_SUBI: return a - i;
		OP_ANDI: return a & i;
		OP_ORI: return a | i;
		OP_EORI: return a ^ i;
		OP_ADD4UI: return a * 4 + i;
		OP_MULI, OP_MULUI: return a * i;
		OP_DIVI: return divide(a, i, 1'b1);
		OP_DIVUI: return divide(a, i, 1'b0);
		OP_LOAD: return a + c + i;
		OP_LOADX: return a + c + (b << f[1:0]);
		OP_JSR: return p + DBW'(sz);
		default: return POISON;
		endcase
	endfunction

	function automatic string test_name(input logic [7:0] o, input logic iter);
		case (o)
		OP_RR: return iter ? "rr_muldiv" : "rr_arith";
		OP_R: return "unary";
		OP_LOGIC: return "logic";
		OP_CMP, OP_CMPI: return "compare";
		OP_SHIFT: return "shift";
		OP_MULI, OP_MULUI, OP_DIVI, OP_DIVUI: return "imm_muldiv";
		OP_LOAD, OP_LOADX: return "agen";
		OP_JSR: return "jsr_link";
		OP_ADDI, OP_SUBI, OP_ANDI, OP_ORI, OP_EORI, OP_ADD4UI: return "imm_arith";
		default: return "undecoded";
		endcase
	endfunction

	always @(posedge clk)
	begin : sample
		logic [DBW-1:0] expect_val;
		logic dvz_next;
		if (!rst_n)
		begin
			ld_prev <= 1'b0;
			div_prev <= 1'b0;
			exp_dvz <= 1'b0;
		end
		else
		begin
			if (ld_prev && done)
			begin
				$display("Error: done was still high in the cycle after ld (op %h fn %h)", op, fn);
				err_cnt++;
			end
			if (div_prev && div_by_zero)
			begin
				$display("FAILED dvz_clear: expected 0, actual 1");
				err_cnt++;
			end
			dvz_next = (ld && div_op) ? 1'b0 : exp_dvz;		// New divide drops the flag
			if (chk_en && done)
			begin
				if (div_op)
					dvz_next = divisor == '0;
				expect_val = model(op, fn, arg_a, arg_b, arg_c, arg_i, pc, insn_size);
				if (result !== expect_val)
				begin
					$display("FAILED %s (op %h fn %h): expected %h, actual %h",
						test_name(op, iter_op), op, fn, expect_val, result);
					err_cnt++;
				end
				if (div_by_zero !== dvz_next)
				begin
					$display("FAILED div_by_zero (op %h): expected %b, actual %b",
						op, dvz_next, div_by_zero);
					err_cnt++;
				end
			end
			else if (chk_en && !iter_op)
			begin
				$display("Error: done was low on a single-cycle op (op %h fn %h)", op, fn);
				err_cnt++;
			end
			ld_prev <= ld && iter_op;
			div_prev <= ld && div_op;
			exp_dvz <= dvz_next;
		end
	end

endmodule

// ==== sim/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb;
	import alu_pkg::*;

	localparam int NUM_RANDOM = 2000;
	localparam int WAIT_LIMIT = 200;		// Cycles allowed for done

	logic clk;
	logic rst_n;
	logic ld;
	logic [7:0] op;
	logic [5:0] fn;
	logic [DBW-1:0] arg_a;
	logic [DBW-1:0] arg_b;
	logic [DBW-1:0] arg_c;
	logic [DBW-1:0] arg_i;
	logic [DBW-1:0] pc;
	logic [3:0] insn_size;
	logic [DBW-1:0] result;
	logic done;
	logic div_by_zero;
	logic chk_en;		// Marks the applied transaction as ready to compare
	logic [15:0] lfsr;
	int mismatches;
	int timeouts;

	alu_core dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.ld(ld),
		.op(op),
		.fn(fn),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.arg_c(arg_c),
		.arg_i(arg_i),
		.pc(pc),
		.insn_size(insn_size),
		.result(result),
		.done(done),
		.div_by_zero(div_by_zero)
	);

	alu_checker chk_i (
		.clk(clk),
		.rst_n(rst_n),
		.chk_en(chk_en),
		.ld(ld),
		.op(op),
		.fn(fn),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.arg_c(arg_c),
		.arg_i(arg_i),
		.pc(pc),
		.insn_size(insn_size),
		.result(result),
		.done(done),
		.div_by_zero(div_by_zero),
		.errors(mismatches)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ========================================================================
	// Random source
	// ========================================================================

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [DBW-1:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[DBW-2:0], lfsr[0]};		// One step per bit
		end
	endtask

	// Corner values come up about half the time
	task automatic pick_operand(output logic [DBW-1:0] v);
		logic [DBW-1:0] sel;
		take_bits(3, sel);
		case (sel[2:0])
		3'd0: v = '0;
		3'd1: v = '1;
		3'd2: v = {1'b1, {(DBW-1){1'b0}}};
		3'd3: take_bits(8, v);		// Small magnitudes
		default: take_bits(DBW, v);
		endcase
	endtask

	task automatic pick_op(output logic [7:0] o, output logic [5:0] f);
		logic [DBW-1:0] r;
		logic [DBW-1:0] s;
		take_bits(13, r);
		take_bits(6, s);
		f = s[5:0];
		case (r[4:0])
		5'd0, 5'd1, 5'd2, 5'd24, 5'd25: o = OP_RR;
		5'd3, 5'd4: o = OP_R;
		5'd5, 5'd6: o = OP_LOGIC;
		5'd7: o = OP_CMP;
		5'd8: o = OP_CMPI;
		5'd9, 5'd10: o = OP_SHIFT;
		5'd11: o = OP_ADDI;
		5'd12: o = OP_SUBI;
		5'd13: o = OP_ANDI;
		5'd14: o = OP_ORI;
		5'd15: o = OP_EORI;
		5'd16: o = OP_ADD4UI;
		5'd17: o = OP_LOAD;
		5'd18: o = OP_LOADX;
		5'd19: o = OP_JSR;
		5'd20: o = OP_MULI;
		5'd21: o = OP_MULUI;
		5'd22: o = OP_DIVI;
		5'd23: o = OP_DIVUI;
		default: o = r[12:5];		// Any opcode, mostly undecoded
		endcase
		if (r[4:0] == 5'd24 || r[4:0] == 5'd25)
			f = FN_MUL + 6'(s[1:0]);
		else if (o == OP_RR && s[2:0] != 3'd7)
			case (s[2:0])
			3'd0, 3'd5: f = FN_ADD;
			3'd1, 3'd6: f = FN_SUB;
			3'd2: f = FN_ADD4U;
			3'd3: f = FN_MIN;
			default: f = FN_MAX;
			endcase
		else if (o == OP_LOGIC || o == OP_SHIFT)
			f = s[5] ? s[5:0] : {3'b000, s[2:0]};
	endtask

	function automatic logic is_iterative(input logic [7:0] o, input logic [5:0] f);
		return (o == OP_RR && f >= FN_MUL && f <= FN_DIVU) || o == OP_MULI ||
			o == OP_MULUI || o == OP_DIVI || o == OP_DIVUI;
	endfunction

	// ========================================================================
	// Transaction driver
	// ========================================================================
	task automatic run_op(input logic [7:0] o, input logic [5:0] f,
		input logic [DBW-1:0] a, input logic [DBW-1:0] b,
		input logic [DBW-1:0] c, input logic [DBW-1:0] i);
		logic [DBW-1:0] link;
		logic [DBW-1:0] size;
		int cycles;
		take_bits(DBW, link);
		take_bits(4, size);
		op <= o;
		fn <= f;
		arg_a <= a;
		arg_b <= b;
		arg_c <= c;
		arg_i <= i;
		pc <= link;
		insn_size <= size[3:0];
		if (!is_iterative(o, f))
		begin
			ld <= 1'b0;
			chk_en <= 1'b1;
			@(posedge clk);		// Checker compares on this edge
		end
		else
		begin
			ld <= 1'b1;
			chk_en <= 1'b0;
			@(posedge clk);
			ld <= 1'b0;
			chk_en <= 1'b1;
			cycles = 0;
			@(posedge clk);
			while (!done && cycles < WAIT_LIMIT)
			begin
				@(posedge clk);
				cycles++;
			end
			if (!done)
			begin
				$display("Timeout: done did not rise within %0d cycles for op %h fn %h",
					WAIT_LIMIT, o, f);
				timeouts++;
			end
		end
	endtask

	initial
	begin : stim
		logic [7:0] o;
		logic [5:0] f;
		logic [DBW-1:0] opa;
		logic [DBW-1:0] opb;
		logic [DBW-1:0] opc;
		logic [DBW-1:0] opi;
		rst_n = 1'b0;
		ld = 1'b0;
		op = OP_RR;
		fn = FN_ADD;
		arg_a = '0;
		arg_b = '0;
		arg_c = '0;
		arg_i = '0;
		pc = '0;
		insn_size = '0;
		chk_en = 1'b0;
		timeouts = 0;
		lfsr = 16'd28704;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// Every shift amount for each shift function code
		for (int amt = 0; amt < 64; amt++)
			for (int k = 0; k < 8; k++)
			begin
				pick_operand(opa);
				take_bits(DBW, opb);
				run_op(OP_SHIFT, 6'(k), opa, {opb[DBW-1:6], 6'(amt)}, '0, '0);
			end

		// Unary ops on zero, all ones and random words
		for (int k = 0; k < 16; k++)
		begin
			take_bits(DBW, opa);
			run_op(OP_R, 6'(k), '0, '0, '0, '0);
			run_op(OP_R, 6'(k), '1, '0, '0, '0);
			run_op(OP_R, 6'(k), opa, '0, '0, '0);
		end

		// Zero divisors, then a clean divide to drop the flag
		pick_operand(opa);
		run_op(OP_RR, FN_DIV, opa, '0, '0, '0);
		run_op(OP_RR, FN_ADD, opa, opa, '0, '0);
		run_op(OP_DIVUI, FN_ADD, opa, '1, '0, '0);
		run_op(OP_RR, FN_DIVU, opa, 64'd3, '0, '0);
		run_op(8'h00, FN_ADD, opa, opa, '0, '0);
		run_op(8'hFF, FN_ADD, opa, opa, '0, '0);

		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			pick_op(o, f);
			pick_operand(opa);
			pick_operand(opb);
			pick_operand(opc);
			pick_operand(opi);
			run_op(o, f, opa, opb, opc, opi);
		end

		chk_en <= 1'b0;
		@(posedge clk);
		$display("Checks complete: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
verilog/alu_pkg.sv
verilog/alu_multiplier.sv
verilog/alu_divider.sv
verilog/alu_shifter.sv
verilog/alu_bitcount.sv
verilog/alu_core.sv
sim/alu_checker.sv
sim/alu_tb.sv

// ==== run.sh ====
#!/bin/bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -f files.f --top-module alu_tb -o alu_sim &&
	./obj_dir/alu_sim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
	echo "Run passed" ||
	{ echo "Run failed"; exit 1; }
